// ==== design/mipsMemPkg.sv ====
package mipsMemPkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;

    // data words and byte addresses share one width
    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] regAddr_t;

    // load and store kinds handled by the memory stage
    typedef enum logic [2:0] {
        LB,
        LBU,
        LH,
        LHU,
        LW,
        SB,
        SH,
        SW
    } memOp_t;

    // request handed over from the execute side
    typedef struct packed {
        memOp_t   op;
        word_t    addr;
        word_t    storeData;
        regAddr_t writeReg;
    } memReq_t;

    // result handed on towards writeback
    typedef struct packed {
        word_t    loadData;
        regAddr_t writeReg;
        logic     isLoad;
        logic     excAddr;
        // faulting address, only meaningful with excAddr
        word_t    badAddr;
    } memResult_t;

endpackage

// ==== design/dramBusPkg.sv ====
package dramBusPkg;

    import mipsMemPkg::*;

    localparam int BYTE_LANES = 4;
    localparam int RAM_ADDR_W = 16;

    // one enable per byte lane, lane 0 is bits 7:0
    typedef logic [BYTE_LANES-1:0] byteEn_t;

    // word index, the RAM keeps only the low bits it needs
    typedef logic [RAM_ADDR_W-1:0] ramAddr_t;

    // single-cycle command towards the data RAM
    typedef struct packed {
        byteEn_t  wen;
        logic     ren;
        ramAddr_t addr;
        word_t    wdata;
    } ramCmd_t;

    // access controller sequence
    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT,
        DONE
    } ctlState_t;

endpackage

// ==== design/storeAlign.sv ====
`timescale 1ns/100ps

module storeAlign
    import mipsMemPkg::*, dramBusPkg::*;
(
    input  memOp_t      op,
    input  logic [1:0]  addrLow,
    input  word_t       storeData,
    output word_t       wdata,
    output byteEn_t     wen
);

    logic [7:0]  lowByte;
    logic [15:0] lowHalf;

    assign lowByte = storeData[7:0];
    assign lowHalf = storeData[15:0];

    always_comb begin
        // loads leave the RAM untouched
        wdata = '0;
        wen   = '0;
        case (op)
            SB: begin
                // same byte on every lane, enable picks the one written
                wdata = {4{lowByte}};
                wen   = byteEn_t'(4'b0001 << addrLow);
            end
            SH: begin
                wdata = {2{lowHalf}};
                if (addrLow[1]) begin
                    wen = 4'b1100;
                end else begin
                    wen = 4'b0011;
                end
            end
            SW: begin
                wdata = storeData;
                wen   = 4'b1111;
            end
            default: begin
                wdata = '0;
                wen   = '0;
            end
        endcase
    end

endmodule

// ==== design/loadExtract.sv ====
`timescale 1ns/100ps

module loadExtract
    import mipsMemPkg::*;
(
    input  memOp_t      op,
    input  logic [1:0]  addrLow,
    input  word_t       rdata,
    output word_t       loadData
);

    logic [7:0]  byteSel;
    logic [15:0] halfSel;

    // little-endian lanes, offset 0 sits in bits 7:0
    assign byteSel = rdata[{addrLow, 3'b000} +: 8];

    // bit 0 of the offset is already checked by the controller
    assign halfSel = addrLow[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        case (op)
            LB: begin
                loadData = {{24{byteSel[7]}}, byteSel};
            end
            LBU: begin
                loadData = {24'b0, byteSel};
            end
            LH: begin
                loadData = {{16{halfSel[15]}}, halfSel};
            end
            LHU: begin
                loadData = {16'b0, halfSel};
            end
            LW: begin
                loadData = rdata;
            end
            default: begin
                // stores return nothing
                loadData = '0;
            end
        endcase
    end

endmodule

// ==== design/waitTimer.sv ====
`timescale 1ns/100ps

module waitTimer #(
    parameter int WAIT_STATES = 3
) (
    input  logic clk,
    input  logic arstN,
    input  logic timerStart,
    output logic timerDone
);

    // wide enough for the load value, never zero bits
    localparam int CNT_W = $clog2(WAIT_STATES + 2);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            count <= '0;
        end else if (timerStart) begin
            // restart wins over a running count
            count <= CNT_W'(WAIT_STATES);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // last wait cycle, the next edge brings the count to zero
    assign timerDone = (count == CNT_W'(1));

endmodule

// ==== design/accessCtl.sv ====
`timescale 1ns/100ps

module accessCtl
    import mipsMemPkg::*, dramBusPkg::*;
#(
    parameter int WAIT_STATES = 3
) (
    input  logic        clk,
    input  logic        arstN,
    input  logic        reqValid,
    input  memReq_t     req,
    input  logic        timerDone,
    input  word_t       loadData,
    input  word_t       wdata,
    input  byteEn_t     wen,
    output logic        timerStart,
    output ramCmd_t     ramCmd,
    output memReq_t     curReq,
    output logic        busy,
    output logic        resValid,
    output memResult_t  res
);

    // without wait states the access completes right after ISSUE
    localparam bit NO_WAIT = (WAIT_STATES == 0);

    ctlState_t state;
    ctlState_t nextState;
    logic      isLoad;
    logic      misaligned;
    logic      doAccess;

    assign isLoad = curReq.op inside {LB, LBU, LH, LHU, LW};

    // alignment rules per access size
    always_comb begin
        case (curReq.op)
            LW, SW: begin
                misaligned = (curReq.addr[1:0] != 2'b00);
            end
            LH, LHU, SH: begin
                misaligned = curReq.addr[0];
            end
            default: begin
                misaligned = 1'b0;
            end
        endcase
    end

    // RAM only sees a command for an aligned request
    assign doAccess = (state == ISSUE) && !misaligned;

    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                if (reqValid) begin
                    nextState = ISSUE;
                end
            end
            ISSUE: begin
                if (misaligned || NO_WAIT) begin
                    nextState = DONE;
                end else begin
                    nextState = WAIT;
                end
            end
            WAIT: begin
                if (timerDone) begin
                    nextState = DONE;
                end
            end
            DONE: begin
                nextState = IDLE;
            end
            default: begin
                nextState = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state    <= IDLE;
            resValid <= 1'b0;
        end else begin
            state    <= nextState;
            resValid <= (state == DONE);
        end
    end

    always_ff @(posedge clk) begin
        // strobes seen while busy are dropped here
        if (state == IDLE && reqValid) begin
            curReq <= req;
        end
        if (state == DONE) begin
            res.loadData <= misaligned ? '0 : loadData;
            res.writeReg <= curReq.writeReg;
            res.isLoad   <= isLoad;
            res.excAddr  <= misaligned;
            res.badAddr  <= misaligned ? curReq.addr : '0;
        end
    end

    assign busy       = (state != IDLE);
    assign timerStart = doAccess && !NO_WAIT;

    assign ramCmd.wen   = doAccess ? wen : '0;
    assign ramCmd.ren   = doAccess && isLoad;
    assign ramCmd.addr  = ramAddr_t'(curReq.addr >> 2);
    assign ramCmd.wdata = wdata;

endmodule

// ==== design/dataRam.sv ====
`timescale 1ns/100ps

module dataRam
    import mipsMemPkg::*, dramBusPkg::*;
#(
    parameter int DEPTH = 256
) (
    input  logic    clk,
    input  ramCmd_t cmd,
    output word_t   rdata
);

    // depth is expected to be a power of two
    localparam int AW = $clog2(DEPTH);

    word_t          mem [DEPTH];
    logic [AW-1:0]  wordIdx;

    // upper address bits wrap around
    assign wordIdx = cmd.addr[AW-1:0];

    // byte-lane writes
    always_ff @(posedge clk) begin
        for (int lane = 0; lane < BYTE_LANES; lane++) begin
            if (cmd.wen[lane]) begin
                mem[wordIdx][8*lane +: 8] <= cmd.wdata[8*lane +: 8];
            end
        end
    end

    // registered read, held until the next read
    always_ff @(posedge clk) begin
        if (cmd.ren) begin
            rdata <= mem[wordIdx];
        end
    end

endmodule

// ==== design/memStage.sv ====
`timescale 1ns/100ps

module memStage
    import mipsMemPkg::*, dramBusPkg::*;
#(
    parameter int WAIT_STATES = 3,
    parameter int DEPTH       = 256
) (
    input  logic        clk,
    input  logic        arstN,
    input  logic        reqValid,
    input  memReq_t     req,
    output logic        busy,
    output logic        resValid,
    output memResult_t  res
);

    ramCmd_t ramCmd;
    word_t   rdata;
    logic    timerStart;
    logic    timerDone;
    memReq_t curReq;
    word_t   wdata;
    byteEn_t wen;
    word_t   loadData;

    accessCtl #(
        .WAIT_STATES (WAIT_STATES)
    ) ctl (
        .clk        (clk),
        .arstN      (arstN),
        .reqValid   (reqValid),
        .req        (req),
        .timerDone  (timerDone),
        .loadData   (loadData),
        .wdata      (wdata),
        .wen        (wen),
        .timerStart (timerStart),
        .ramCmd     (ramCmd),
        .curReq     (curReq),
        .busy       (busy),
        .resValid   (resValid),
        .res        (res)
    );

    waitTimer #(
        .WAIT_STATES (WAIT_STATES)
    ) timer (
        .clk        (clk),
        .arstN      (arstN),
        .timerStart (timerStart),
        .timerDone  (timerDone)
    );

    // lane steering works on the captured request
    storeAlign storeLanes (
        .op        (curReq.op),
        .addrLow   (curReq.addr[1:0]),
        .storeData (curReq.storeData),
        .wdata     (wdata),
        .wen       (wen)
    );

    loadExtract loadLanes (
        .op       (curReq.op),
        .addrLow  (curReq.addr[1:0]),
        .rdata    (rdata),
        .loadData (loadData)
    );

    dataRam #(
        .DEPTH (DEPTH)
    ) ram (
        .clk   (clk),
        .cmd   (ramCmd),
        .rdata (rdata)
    );

endmodule

// ==== verif/memStageTb.sv ====
`timescale 1ns/100ps

module memStageTb
    import mipsMemPkg::*;
();

    localparam int EXP_WAITS = 3;
    localparam int TIMEOUT   = 50;
    localparam int REF_BYTES = 1024;

    logic       clk = 1'b0;
    logic       arstN;
    logic       reqValid;
    memReq_t    req;
    logic       busy;
    logic       resValid;
    memResult_t res;

    // stimulus table, one slot per test
    string   names[$];
    memReq_t reqTab[$];
    bit      excTab[$];
    word_t   dataTab[$];
    bit      dropTab[$];

    // byte-wide reference of the data RAM, little-endian
    logic [7:0] refMem [REF_BYTES];

    integer  seed      = 32'h4909;
    int      passCount = 0;
    int      failCount = 0;
    bit      hung      = 1'b0;
    memReq_t dropReq;

    memStage DUT (
        .clk      (clk),
        .arstN    (arstN),
        .reqValid (reqValid),
        .req      (req),
        .busy     (busy),
        .resValid (resValid),
        .res      (res)
    );

    always #10 clk = ~clk;

    function automatic bit isLoadOp(input memOp_t op);
        return op inside {LB, LBU, LH, LHU, LW};
    endfunction

    // words on 4-byte, halfwords on 2-byte boundaries
    function automatic bit alignedRef(input memOp_t op, input word_t addr);
        if (op == LW || op == SW) begin
            return addr[1:0] == 2'b00;
        end
        if (op == LH || op == LHU || op == SH) begin
            return !addr[0];
        end
        return 1'b1;
    endfunction

    function automatic word_t refLoad(input memOp_t op, input word_t addr);
        logic [9:0] a;
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        logic [7:0] b3;
        a  = addr[9:0];
        b0 = refMem[a];
        b1 = refMem[a + 10'd1];
        b2 = refMem[a + 10'd2];
        b3 = refMem[a + 10'd3];
        case (op)
            LB:      return {{24{b0[7]}}, b0};
            LBU:     return {24'b0, b0};
            LH:      return {{16{b1[7]}}, b1, b0};
            LHU:     return {16'b0, b1, b0};
            LW:      return {b3, b2, b1, b0};
            default: return '0;
        endcase
    endfunction

    task automatic refStore(input memOp_t op, input word_t addr, input word_t data);
        logic [9:0] a;
        a         = addr[9:0];
        refMem[a] = data[7:0];
        if (op == SH || op == SW) begin
            refMem[a + 10'd1] = data[15:8];
        end
        if (op == SW) begin
            refMem[a + 10'd2] = data[23:16];
            refMem[a + 10'd3] = data[31:24];
        end
    endtask

    task automatic addEntry(input string name, input memOp_t op, input word_t addr,
                            input word_t data, input regAddr_t wreg, input bit drop);
        memReq_t r;
        bit      exc;
        word_t   expData;
        r.op        = op;
        r.addr      = addr;
        r.storeData = data;
        r.writeReg  = wreg;
        exc         = !alignedRef(op, addr);
        expData     = '0;
        // only aligned stores reach the RAM
        if (!exc && !isLoadOp(op)) begin
            refStore(op, addr, data);
        end else if (!exc) begin
            expData = refLoad(op, addr);
        end
        names.push_back(name);
        reqTab.push_back(r);
        excTab.push_back(exc);
        dataTab.push_back(expData);
        dropTab.push_back(drop);
    endtask

    task automatic buildTable();
        dropReq = '{op: SW, addr: 32'h0, storeData: 32'hDEADBEEF, writeReg: 5'd31};
        // word stores and loads
        addEntry("sw-0",      SW,  32'h000, 32'h11223344, 5'd1,  1'b0);
        addEntry("sw-4",      SW,  32'h004, $random(seed), 5'd2, 1'b0);
        addEntry("sw-3fc",    SW,  32'h3FC, $random(seed), 5'd3, 1'b0);
        addEntry("sw-40",     SW,  32'h040, 32'h80FF7F01, 5'd4,  1'b0);
        addEntry("sw-8",      SW,  32'h008, $random(seed), 5'd5, 1'b0);
        addEntry("sw-c",      SW,  32'h00C, 32'hFFFFFFFF, 5'd6,  1'b0);
        addEntry("lw-0",      LW,  32'h000, 32'h0,        5'd7,  1'b0);
        addEntry("lw-4",      LW,  32'h004, 32'h0,        5'd8,  1'b0);
        addEntry("lw-3fc",    LW,  32'h3FC, 32'h0,        5'd9,  1'b0);
        addEntry("lw-40",     LW,  32'h040, 32'h0,        5'd10, 1'b0);
        // byte and halfword stores
        addEntry("sb-8",      SB,  32'h008, 32'h123456A5, 5'd11, 1'b0);
        addEntry("sb-9",      SB,  32'h009, $random(seed), 5'd12, 1'b0);
        addEntry("sb-a",      SB,  32'h00A, 32'h0000005A, 5'd13, 1'b0);
        addEntry("sb-b",      SB,  32'h00B, 32'hFFFFFF81, 5'd14, 1'b0);
        addEntry("lw-8-sb",   LW,  32'h008, 32'h0,        5'd15, 1'b0);
        addEntry("sh-c",      SH,  32'h00C, 32'h0000BEEF, 5'd16, 1'b0);
        addEntry("lw-c-sh0",  LW,  32'h00C, 32'h0,        5'd17, 1'b0);
        addEntry("sh-e",      SH,  32'h00E, $random(seed), 5'd18, 1'b0);
        addEntry("lw-c-sh1",  LW,  32'h00C, 32'h0,        5'd19, 1'b0);
        // sign and zero extension
        addEntry("lb-40",     LB,  32'h040, 32'h0,        5'd20, 1'b0);
        addEntry("lb-41",     LB,  32'h041, 32'h0,        5'd21, 1'b0);
        addEntry("lb-42",     LB,  32'h042, 32'h0,        5'd22, 1'b0);
        addEntry("lbu-42",    LBU, 32'h042, 32'h0,        5'd23, 1'b0);
        addEntry("lb-43",     LB,  32'h043, 32'h0,        5'd24, 1'b0);
        addEntry("lbu-43",    LBU, 32'h043, 32'h0,        5'd25, 1'b0);
        addEntry("lh-40",     LH,  32'h040, 32'h0,        5'd26, 1'b0);
        addEntry("lh-42",     LH,  32'h042, 32'h0,        5'd27, 1'b0);
        addEntry("lhu-40",    LHU, 32'h040, 32'h0,        5'd28, 1'b0);
        addEntry("lhu-42",    LHU, 32'h042, 32'h0,        5'd29, 1'b0);
        addEntry("lh-e",      LH,  32'h00E, 32'h0,        5'd30, 1'b0);
        // misaligned requests leave memory alone
        addEntry("lw-41",     LW,  32'h041, 32'h0,        5'd1,  1'b0);
        addEntry("sw-42",     SW,  32'h042, $random(seed), 5'd2, 1'b0);
        addEntry("sw-d",      SW,  32'h00D, 32'h00000000, 5'd3,  1'b0);
        addEntry("lh-41",     LH,  32'h041, 32'h0,        5'd4,  1'b0);
        addEntry("lhu-43",    LHU, 32'h043, 32'h0,        5'd5,  1'b0);
        addEntry("sh-9",      SH,  32'h009, 32'h0000CAFE, 5'd6,  1'b0);
        addEntry("lw-40-chk", LW,  32'h040, 32'h0,        5'd7,  1'b0);
        addEntry("lw-8-chk",  LW,  32'h008, 32'h0,        5'd8,  1'b0);
        addEntry("lw-c-chk",  LW,  32'h00C, 32'h0,        5'd9,  1'b0);
        // extra strobe while busy is ignored
        addEntry("lw-0-drop", LW,  32'h000, 32'h0,        5'd10, 1'b1);
        addEntry("lw-0-chk",  LW,  32'h000, 32'h0,        5'd11, 1'b0);
    endtask

    task automatic checkValue(input string testName, input string field,
                              input word_t expected, input word_t actual, inout bit ok);
        assert (actual == expected) else begin
            $display("ERROR %s %s expected %h actual %h", testName, field, expected, actual);
            ok = 1'b0;
        end
    endtask

    task automatic reportTest(input string testName, input bit ok);
        if (ok) begin
            passCount++;
            $display("test %-10s ok", testName);
        end else begin
            failCount++;
            $display("test %-10s FAILED", testName);
        end
    endtask

    task automatic waitIdle(input string testName);
        int n;
        n = 0;
        while (busy && !hung) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                hung = 1'b1;
                $display("timeout waiting for busy to fall before test %s", testName);
            end
        end
    endtask

    task automatic endRun();
        $display("tests passed %0d failed %0d", passCount, failCount);
        if (failCount == 0 && !hung) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    initial begin
        bit ok;
        int cycles;
        int quiet;
        int expLat;
        arstN    = 1'b0;
        reqValid = 1'b0;
        req      = '0;
        buildTable();
        repeat (5) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        ok    = 1'b1;
        assert (!busy && !resValid) else begin
            $display("busy or resValid is high right after reset");
            ok = 1'b0;
        end
        reportTest("reset", ok);
        for (int i = 0; i < names.size(); i++) begin
            waitIdle(names[i]);
            if (hung) begin
                break;
            end
            req      = reqTab[i];
            reqValid = 1'b1;
            @(negedge clk);
            reqValid = 1'b0;
            cycles   = 0;
            ok       = 1'b1;
            while (!resValid && !hung) begin
                // busy covers the whole access up to the result strobe
                assert (busy) else begin
                    $display("busy is low while test %s is still in flight", names[i]);
                    ok = 1'b0;
                end
                @(negedge clk);
                cycles++;
                // second strobe lands while the FSM waits on the RAM
                if (dropTab[i] && cycles == 1) begin
                    req      = dropReq;
                    reqValid = 1'b1;
                end else begin
                    reqValid = 1'b0;
                end
                if (cycles > TIMEOUT) begin
                    hung = 1'b1;
                    $display("timeout waiting for the result of test %s", names[i]);
                end
            end
            if (hung) begin
                break;
            end
            expLat = excTab[i] ? 2 : EXP_WAITS + 2;
            checkValue(names[i], "latency", word_t'(expLat), word_t'(cycles), ok);
            checkValue(names[i], "loadData", dataTab[i], res.loadData, ok);
            checkValue(names[i], "writeReg", {27'b0, reqTab[i].writeReg},
                       {27'b0, res.writeReg}, ok);
            checkValue(names[i], "isLoad", {31'b0, isLoadOp(reqTab[i].op)},
                       {31'b0, res.isLoad}, ok);
            checkValue(names[i], "excAddr", {31'b0, excTab[i]}, {31'b0, res.excAddr}, ok);
            checkValue(names[i], "badAddr", excTab[i] ? reqTab[i].addr : '0,
                       res.badAddr, ok);
            assert (!busy) else begin
                $display("busy still high together with the result of test %s", names[i]);
                ok = 1'b0;
            end
            // result strobe is one cycle, watch longer after a dropped strobe
            quiet = dropTab[i] ? EXP_WAITS + 4 : 1;
            for (int q = 0; q < quiet; q++) begin
                @(negedge clk);
                assert (!resValid) else begin
                    $display("unexpected extra result strobe after test %s", names[i]);
                    ok = 1'b0;
                end
            end
            reportTest(names[i], ok);
        end
        if (hung) begin
            failCount++;
        end
        endRun();
    end

endmodule

// ==== memStage.f ====
design/mipsMemPkg.sv
design/dramBusPkg.sv
design/storeAlign.sv
design/loadExtract.sv
design/waitTimer.sv
design/accessCtl.sv
design/dataRam.sv
design/memStage.sv
verif/memStageTb.sv

// ==== runSim.sh ====
#!/bin/sh
# build and run the memStage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module memStageTb -f memStage.f -o memStageSim

out=$(./obj_dir/memStageSim)
echo "$out"

if echo "$out" | grep -q "All checks passed"; then
    exit 0
fi
exit 1
